// File: mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] alu_op_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // alu ops, one bit each
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam alu_op_t ALU_ADD  = 12'h001;
    localparam alu_op_t ALU_SUB  = 12'h002;
    localparam alu_op_t ALU_SLT  = 12'h004;
    localparam alu_op_t ALU_SLTU = 12'h008;
    localparam alu_op_t ALU_SLL  = 12'h010;
    localparam alu_op_t ALU_SRL  = 12'h020;
    localparam alu_op_t ALU_SRA  = 12'h040;
    localparam alu_op_t ALU_LUI  = 12'h080;
    localparam alu_op_t ALU_OR   = 12'h100;
    localparam alu_op_t ALU_XOR  = 12'h200;
    localparam alu_op_t ALU_AND  = 12'h400;
    localparam alu_op_t ALU_NOR  = 12'h800;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_BLEZ    = 6'h06;
    localparam logic [5:0] OP_BGTZ    = 6'h07;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LB      = 6'h20;
    localparam logic [5:0] OP_LH      = 6'h21;
    localparam logic [5:0] OP_LWL     = 6'h22;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_LBU     = 6'h24;
    localparam logic [5:0] OP_LHU     = 6'h25;
    localparam logic [5:0] OP_LWR     = 6'h26;
    localparam logic [5:0] OP_SB      = 6'h28;
    localparam logic [5:0] OP_SH      = 6'h29;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // special function field
    localparam logic [5:0] FN_SLL   = 6'h00;
    localparam logic [5:0] FN_SRL   = 6'h02;
    localparam logic [5:0] FN_SRA   = 6'h03;
    localparam logic [5:0] FN_SLLV  = 6'h04;
    localparam logic [5:0] FN_SRLV  = 6'h06;
    localparam logic [5:0] FN_SRAV  = 6'h07;
    localparam logic [5:0] FN_JR    = 6'h08;
    localparam logic [5:0] FN_JALR  = 6'h09;
    localparam logic [5:0] FN_MFHI  = 6'h10;
    localparam logic [5:0] FN_MTHI  = 6'h11;
    localparam logic [5:0] FN_MFLO  = 6'h12;
    localparam logic [5:0] FN_MTLO  = 6'h13;
    localparam logic [5:0] FN_MULT  = 6'h18;
    localparam logic [5:0] FN_MULTU = 6'h19;
    localparam logic [5:0] FN_DIV   = 6'h1a;
    localparam logic [5:0] FN_DIVU  = 6'h1b;
    localparam logic [5:0] FN_ADD   = 6'h20;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUB   = 6'h22;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;
    localparam logic [5:0] FN_NOR   = 6'h27;
    localparam logic [5:0] FN_SLT   = 6'h2a;
    localparam logic [5:0] FN_SLTU  = 6'h2b;

    // regimm branches live in the rt field
    localparam reg_addr_t RT_BLTZ   = 5'h00;
    localparam reg_addr_t RT_BGEZ   = 5'h01;
    localparam reg_addr_t RT_BLTZAL = 5'h10;
    localparam reg_addr_t RT_BGEZAL = 5'h11;

    typedef struct packed {
        logic seq;
        logic branch;
        logic jump;
        logic jreg;
    } next_pc_sel_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    a_is_pc;
        logic    a_is_rs;
        logic    a_is_shamt;
        logic    b_is_rt;
        logic    b_is_imm;
        logic    b_is_8;
        logic    imm_sign_ext;
        logic    mem_w;
        logic    mem_b;
        logic    mem_h;
        logic    mem_bu;
        logic    mem_hu;
        logic    mem_wen;
        logic    lwl;
        logic    lwr;
        logic    reg_write;
        logic    wa_rd;
        logic    wa_rt;
        logic    wa_31;
        logic    wb_is_mem;
        logic    res_alu;
        logic    res_hi;
        logic    res_lo;
        logic    is_mult;
        logic    is_multu;
        logic    is_div;
        logic    is_divu;
        logic    hi_wen;
        logic    lo_wen;
    } ctrl_t;

    typedef struct packed {
        logic      valid;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t dest;
        logic      mem_w;
        logic      mem_b;
        logic      mem_h;
        logic      mem_bu;
        logic      mem_hu;
        logic      mem_wen;
        logic      lwl;
        logic      lwr;
        logic      reg_write;
        logic      wb_is_mem;
        logic      res_alu;
        logic      res_hi;
        logic      res_lo;
        logic      is_mult;
        logic      is_multu;
        logic      is_div;
        logic      is_divu;
        logic      hi_wen;
        logic      lo_wen;
    } ex_out_t;

endpackage

// File: branch_ctrl.sv
`timescale 1ns/1ps

module branch_ctrl (
    input  logic                en,
    input  logic [5:0]          opcode,
    input  mips_pkg::reg_addr_t rt,
    input  mips_pkg::word_t     rs_data,
    input  mips_pkg::word_t     rt_data,
    output logic                take,
    output logic                link
);

    logic is_regimm;
    logic eq;
    logic rs_neg;
    logic rs_zero;
    logic ltz;
    logic gez;
    logic cond;

    assign is_regimm = opcode == mips_pkg::OP_REGIMM;
    assign eq        = rs_data == rt_data;
    assign rs_neg    = rs_data[31];
    assign rs_zero   = rs_data == '0;

    // regimm flavours with and without link
    assign ltz = is_regimm & ((rt == mips_pkg::RT_BLTZ) | (rt == mips_pkg::RT_BLTZAL));
    assign gez = is_regimm & ((rt == mips_pkg::RT_BGEZ) | (rt == mips_pkg::RT_BGEZAL));

    assign cond = ((opcode == mips_pkg::OP_BEQ) & eq)
                | ((opcode == mips_pkg::OP_BNE) & ~eq)
                | ((opcode == mips_pkg::OP_BLEZ) & (rs_neg | rs_zero))
                | ((opcode == mips_pkg::OP_BGTZ) & ~rs_neg & ~rs_zero)
                | (ltz & rs_neg)
                | (gez & ~rs_neg);

    assign take = en & cond;

    // r31 gets pc+8 even when not taken
    assign link = is_regimm & ((rt == mips_pkg::RT_BLTZAL) | (rt == mips_pkg::RT_BGEZAL));

endmodule

// File: control.sv
`timescale 1ns/1ps

module control (
    input  logic                   id_valid,
    input  logic [5:0]             opcode,
    input  logic [5:0]             func,
    input  mips_pkg::reg_addr_t    rt,
    input  mips_pkg::word_t        rs_data,
    input  mips_pkg::word_t        rt_data,
    output mips_pkg::ctrl_t        ctrl,
    output mips_pkg::next_pc_sel_t next_pc_sel
);

    logic is_rtype, imm_arith, is_load, is_store;
    logic is_addi, is_addiu, is_slti, is_sltiu, is_andi, is_ori, is_xori, is_lui;
    logic is_j, is_jal;
    logic is_lb, is_lbu, is_lh, is_lhu, is_lw, is_lwl, is_lwr, is_sb, is_sh, is_sw;
    logic r_add, r_sub, r_slt, r_sltu, r_sll, r_srl, r_sra, shift_const;
    logic r_or, r_xor, r_and, r_nor, r_jr, r_jalr, r_write;
    logic r_mfhi, r_mflo, r_mthi, r_mtlo, r_mult, r_multu, r_div, r_divu;
    logic br_take, br_link, link, link_31;
    logic pc_jump, pc_jreg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcode decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign is_rtype = opcode == mips_pkg::OP_SPECIAL;
    assign is_j     = opcode == mips_pkg::OP_J;
    assign is_jal   = opcode == mips_pkg::OP_JAL;
    assign is_addi  = opcode == mips_pkg::OP_ADDI;
    assign is_addiu = opcode == mips_pkg::OP_ADDIU;
    assign is_slti  = opcode == mips_pkg::OP_SLTI;
    assign is_sltiu = opcode == mips_pkg::OP_SLTIU;
    assign is_andi  = opcode == mips_pkg::OP_ANDI;
    assign is_ori   = opcode == mips_pkg::OP_ORI;
    assign is_xori  = opcode == mips_pkg::OP_XORI;
    assign is_lui   = opcode == mips_pkg::OP_LUI;
    assign is_lb    = opcode == mips_pkg::OP_LB;
    assign is_lh    = opcode == mips_pkg::OP_LH;
    assign is_lwl   = opcode == mips_pkg::OP_LWL;
    assign is_lw    = opcode == mips_pkg::OP_LW;
    assign is_lbu   = opcode == mips_pkg::OP_LBU;
    assign is_lhu   = opcode == mips_pkg::OP_LHU;
    assign is_lwr   = opcode == mips_pkg::OP_LWR;
    assign is_sb    = opcode == mips_pkg::OP_SB;
    assign is_sh    = opcode == mips_pkg::OP_SH;
    assign is_sw    = opcode == mips_pkg::OP_SW;

    assign is_load   = is_lb | is_lbu | is_lh | is_lhu | is_lw | is_lwl | is_lwr;
    assign is_store  = is_sb | is_sh | is_sw;
    assign imm_arith = is_addi | is_addiu | is_slti | is_sltiu | is_lui
                     | is_andi | is_ori | is_xori;

    // special funcs, already qualified by is_rtype
    assign r_add  = is_rtype & ((func == mips_pkg::FN_ADD) | (func == mips_pkg::FN_ADDU));
    assign r_sub  = is_rtype & ((func == mips_pkg::FN_SUB) | (func == mips_pkg::FN_SUBU));
    assign r_slt  = is_rtype & (func == mips_pkg::FN_SLT);
    assign r_sltu = is_rtype & (func == mips_pkg::FN_SLTU);
    assign r_sll  = is_rtype & ((func == mips_pkg::FN_SLL) | (func == mips_pkg::FN_SLLV));
    assign r_srl  = is_rtype & ((func == mips_pkg::FN_SRL) | (func == mips_pkg::FN_SRLV));
    assign r_sra  = is_rtype & ((func == mips_pkg::FN_SRA) | (func == mips_pkg::FN_SRAV));
    assign r_or   = is_rtype & (func == mips_pkg::FN_OR);
    assign r_xor  = is_rtype & (func == mips_pkg::FN_XOR);
    assign r_and  = is_rtype & (func == mips_pkg::FN_AND);
    assign r_nor  = is_rtype & (func == mips_pkg::FN_NOR);
    assign r_jr   = is_rtype & (func == mips_pkg::FN_JR);
    assign r_jalr = is_rtype & (func == mips_pkg::FN_JALR);
    assign r_mfhi = is_rtype & (func == mips_pkg::FN_MFHI);
    assign r_mflo = is_rtype & (func == mips_pkg::FN_MFLO);
    assign r_mthi = is_rtype & (func == mips_pkg::FN_MTHI);
    assign r_mtlo = is_rtype & (func == mips_pkg::FN_MTLO);
    assign r_mult  = is_rtype & (func == mips_pkg::FN_MULT);
    assign r_multu = is_rtype & (func == mips_pkg::FN_MULTU);
    assign r_div   = is_rtype & (func == mips_pkg::FN_DIV);
    assign r_divu  = is_rtype & (func == mips_pkg::FN_DIVU);

    // constant shifts take shamt as operand a
    assign shift_const = is_rtype & ((func == mips_pkg::FN_SLL) | (func == mips_pkg::FN_SRL)
                                   | (func == mips_pkg::FN_SRA));

    // no gpr write for jr, hi/lo moves in, mult/div
    assign r_write = is_rtype & ~(r_jr | r_jalr | r_mthi | r_mtlo
                                | r_mult | r_multu | r_div | r_divu);

    assign link    = is_jal | br_link | r_jalr;
    assign link_31 = is_jal | br_link;

    branch_ctrl u_branch_ctrl (
        .en      (id_valid),
        .opcode  (opcode),
        .rt      (rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .take    (br_take),
        .link    (br_link)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // steering
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        ctrl.alu_op =
              ({12{r_add | is_addi | is_addiu | is_load | is_store | link}} & mips_pkg::ALU_ADD)
            | ({12{r_sub}}             & mips_pkg::ALU_SUB)
            | ({12{r_slt | is_slti}}   & mips_pkg::ALU_SLT)
            | ({12{r_sltu | is_sltiu}} & mips_pkg::ALU_SLTU)
            | ({12{r_sll}}             & mips_pkg::ALU_SLL)
            | ({12{r_srl}}             & mips_pkg::ALU_SRL)
            | ({12{r_sra}}             & mips_pkg::ALU_SRA)
            | ({12{is_lui}}            & mips_pkg::ALU_LUI)
            | ({12{r_or | is_ori}}     & mips_pkg::ALU_OR)
            | ({12{r_xor | is_xori}}   & mips_pkg::ALU_XOR)
            | ({12{r_and | is_andi}}   & mips_pkg::ALU_AND)
            | ({12{r_nor}}             & mips_pkg::ALU_NOR);

        ctrl.a_is_pc      = link;          // pc+8 for links
        ctrl.a_is_shamt   = shift_const;
        ctrl.a_is_rs      = ~link & ~shift_const;
        ctrl.b_is_8       = link;
        ctrl.b_is_rt      = is_rtype & ~link;
        ctrl.b_is_imm     = is_load | is_store | imm_arith;
        ctrl.imm_sign_ext = ~(is_andi | is_ori | is_xori);

        ctrl.mem_w   = is_lw | is_lwl | is_lwr | is_sw;
        ctrl.mem_b   = is_lb | is_sb;
        ctrl.mem_h   = is_lh | is_sh;
        ctrl.mem_bu  = is_lbu;
        ctrl.mem_hu  = is_lhu;
        ctrl.mem_wen = is_store;
        ctrl.lwl     = is_lwl;
        ctrl.lwr     = is_lwr;

        ctrl.reg_write = r_write | is_load | link | imm_arith;
        ctrl.wa_31     = link_31;
        ctrl.wa_rd     = is_rtype & ~link_31;
        ctrl.wa_rt     = ~link_31 & ~is_rtype;
        ctrl.wb_is_mem = is_load;

        ctrl.res_hi  = r_mfhi;
        ctrl.res_lo  = r_mflo;
        ctrl.res_alu = ~r_mfhi & ~r_mflo;

        ctrl.is_mult  = r_mult;
        ctrl.is_multu = r_multu;
        ctrl.is_div   = r_div;
        ctrl.is_divu  = r_divu;
        ctrl.hi_wen   = r_mthi;
        ctrl.lo_wen   = r_mtlo;
    end

    assign pc_jump = id_valid & (is_j | is_jal);
    assign pc_jreg = id_valid & (r_jr | r_jalr);

    assign next_pc_sel = '{seq:    ~(br_take | pc_jump | pc_jreg),
                           branch: br_take,
                           jump:   pc_jump,
                           jreg:   pc_jreg};

    always_comb begin
        a_alu_op_onehot: assert final ($onehot0(ctrl.alu_op));
        a_next_pc_onehot: assert final ($onehot(next_pc_sel));
    end

endmodule

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  mips_pkg::reg_addr_t ra1,
    input  mips_pkg::reg_addr_t ra2,
    output mips_pkg::word_t     rd1,
    output mips_pkg::word_t     rd2,
    input  logic                we,
    input  mips_pkg::reg_addr_t wa,
    input  mips_pkg::word_t     wd
);

    mips_pkg::word_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin   // r0 stays zero
            regs[wa] <= wd;
        end
    end

    // no bypass, a write shows up next cycle
    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

    a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        ((ra1 == '0) |-> (rd1 == '0)) and ((ra2 == '0) |-> (rd2 == '0)));

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu (
    input  mips_pkg::alu_op_t op,
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    output mips_pkg::word_t   y
);

    logic [4:0]      sa;
    mips_pkg::word_t sum;
    mips_pkg::word_t diff;
    logic            lt_s;
    logic            lt_u;

    assign sa   = a[4:0];      // shamt or rs, low bits only
    assign sum  = a + b;
    assign diff = a - b;
    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    // and-or mux over the one-hot op
    assign y = ({32{|(op & mips_pkg::ALU_ADD)}}  & sum)
             | ({32{|(op & mips_pkg::ALU_SUB)}}  & diff)
             | ({32{|(op & mips_pkg::ALU_SLT)}}  & {31'd0, lt_s})
             | ({32{|(op & mips_pkg::ALU_SLTU)}} & {31'd0, lt_u})
             | ({32{|(op & mips_pkg::ALU_SLL)}}  & (b << sa))
             | ({32{|(op & mips_pkg::ALU_SRL)}}  & (b >> sa))
             | ({32{|(op & mips_pkg::ALU_SRA)}}  & mips_pkg::word_t'($signed(b) >>> sa))
             | ({32{|(op & mips_pkg::ALU_LUI)}}  & {b[15:0], 16'h0000})
             | ({32{|(op & mips_pkg::ALU_OR)}}   & (a | b))
             | ({32{|(op & mips_pkg::ALU_XOR)}}  & (a ^ b))
             | ({32{|(op & mips_pkg::ALU_AND)}}  & (a & b))
             | ({32{|(op & mips_pkg::ALU_NOR)}}  & ~(a | b));

endmodule

// File: ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                id_valid,
    input  mips_pkg::ctrl_t     ctrl,
    input  mips_pkg::word_t     pc,
    input  mips_pkg::word_t     rs_data,
    input  mips_pkg::word_t     rt_data,
    input  logic [15:0]         imm,
    input  logic [4:0]          shamt,
    input  mips_pkg::reg_addr_t rd,
    input  mips_pkg::reg_addr_t rt,
    output mips_pkg::ex_out_t   ex_out
);

    mips_pkg::word_t     imm_ext;
    mips_pkg::word_t     op_a;
    mips_pkg::word_t     op_b;
    mips_pkg::word_t     alu_y;
    mips_pkg::reg_addr_t dest;
    mips_pkg::ex_out_t   ex_d;

    assign imm_ext = ctrl.imm_sign_ext ? {{16{imm[15]}}, imm} : {16'h0000, imm};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operand and destination select on one-hot flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign op_a = ({32{ctrl.a_is_pc}}    & pc)
                | ({32{ctrl.a_is_shamt}} & {27'd0, shamt})
                | ({32{ctrl.a_is_rs}}    & rs_data);

    assign op_b = ({32{ctrl.b_is_rt}}  & rt_data)
                | ({32{ctrl.b_is_imm}} & imm_ext)
                | ({32{ctrl.b_is_8}}   & 32'd8);

    assign dest = ({5{ctrl.wa_rd}} & rd)
                | ({5{ctrl.wa_rt}} & rt)
                | ({5{ctrl.wa_31}} & 5'd31);

    alu u_alu (
        .op (ctrl.alu_op),
        .a  (op_a),
        .b  (op_b),
        .y  (alu_y)
    );

    always_comb begin
        ex_d.valid      = id_valid;
        ex_d.alu_result = alu_y;
        ex_d.store_data = rt_data;
        ex_d.dest       = dest;
        ex_d.mem_w      = ctrl.mem_w;
        ex_d.mem_b      = ctrl.mem_b;
        ex_d.mem_h      = ctrl.mem_h;
        ex_d.mem_bu     = ctrl.mem_bu;
        ex_d.mem_hu     = ctrl.mem_hu;
        ex_d.mem_wen    = ctrl.mem_wen & id_valid;
        ex_d.lwl        = ctrl.lwl;
        ex_d.lwr        = ctrl.lwr;
        ex_d.reg_write  = ctrl.reg_write & id_valid;
        ex_d.wb_is_mem  = ctrl.wb_is_mem;
        ex_d.res_alu    = ctrl.res_alu;
        ex_d.res_hi     = ctrl.res_hi;
        ex_d.res_lo     = ctrl.res_lo;
        // state changing md ops also dropped on a bubble
        ex_d.is_mult    = ctrl.is_mult & id_valid;
        ex_d.is_multu   = ctrl.is_multu & id_valid;
        ex_d.is_div     = ctrl.is_div & id_valid;
        ex_d.is_divu    = ctrl.is_divu & id_valid;
        ex_d.hi_wen     = ctrl.hi_wen & id_valid;
        ex_d.lo_wen     = ctrl.lo_wen & id_valid;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_out <= '0;
        end else begin
            ex_out <= ex_d;
        end
    end

    a_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({ctrl.a_is_pc, ctrl.a_is_shamt, ctrl.a_is_rs})
        && $onehot0({ctrl.b_is_rt, ctrl.b_is_imm, ctrl.b_is_8})
        && $onehot0({ctrl.wa_rd, ctrl.wa_rt, ctrl.wa_31}));

endmodule

// File: mips_id_ex.sv
`timescale 1ns/1ps

module mips_id_ex (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   id_valid,
    input  mips_pkg::word_t        instr,
    input  mips_pkg::word_t        pc,
    input  logic                   wb_en,
    input  mips_pkg::reg_addr_t    wb_addr,
    input  mips_pkg::word_t        wb_data,
    output mips_pkg::next_pc_sel_t next_pc_sel,
    output mips_pkg::word_t        branch_target,
    output mips_pkg::word_t        jump_target,
    output mips_pkg::word_t        jr_target,
    output mips_pkg::ex_out_t      ex_out
);

    logic [5:0]          opcode;
    logic [5:0]          func;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t rd;
    logic [4:0]          shamt;
    logic [15:0]         imm;
    logic [25:0]         instr_index;
    mips_pkg::word_t     pc_plus4;
    mips_pkg::word_t     rs_data;
    mips_pkg::word_t     rt_data;
    mips_pkg::ctrl_t     ctrl;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fields and targets
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign opcode      = instr[31:26];
    assign rs          = instr[25:21];
    assign rt          = instr[20:16];
    assign rd          = instr[15:11];
    assign shamt       = instr[10:6];
    assign func        = instr[5:0];
    assign imm         = instr[15:0];
    assign instr_index = instr[25:0];

    assign pc_plus4      = pc + 32'd4;   // delay slot pc
    assign branch_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
    assign jump_target   = {pc_plus4[31:28], instr_index, 2'b00};
    assign jr_target     = rs_data;

    control u_control (
        .id_valid    (id_valid),
        .opcode      (opcode),
        .func        (func),
        .rt          (rt),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .ctrl        (ctrl),
        .next_pc_sel (next_pc_sel)
    );

    reg_file u_reg_file (
        .clk   (clk),
        .rst_n (rst_n),
        .ra1   (rs),
        .ra2   (rt),
        .rd1   (rs_data),
        .rd2   (rt_data),
        .we    (wb_en),
        .wa    (wb_addr),
        .wd    (wb_data)
    );

    ex_stage u_ex_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .id_valid (id_valid),
        .ctrl     (ctrl),
        .pc       (pc),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .imm      (imm),
        .shamt    (shamt),
        .rd       (rd),
        .rt       (rt),
        .ex_out   (ex_out)
    );

endmodule

// File: tb_mips_id_ex.sv
`timescale 1ns/1ps

module tb_mips_id_ex;

    localparam int MAX_WAIT = 8;

    logic                   clk;
    logic                   rst_n;
    logic                   id_valid;
    mips_pkg::word_t        instr;
    mips_pkg::word_t        pc;
    logic                   wb_en;
    mips_pkg::reg_addr_t    wb_addr;
    mips_pkg::word_t        wb_data;
    mips_pkg::next_pc_sel_t next_pc_sel;
    mips_pkg::word_t        branch_target;
    mips_pkg::word_t        jump_target;
    mips_pkg::word_t        jr_target;
    mips_pkg::ex_out_t      ex_out;

    // fields of the current vector line
    logic [8*24-1:0]  test_name;
    logic [8*8-1:0]   kind;
    logic [8*200-1:0] line;
    logic [31:0]      v_pc, v_instr, v_valid, v_sel, v_target;
    logic [31:0]      v_alu, v_dest, v_rw, v_memf, v_sdata;
    logic [31:0]      v_addr, v_data;

    int fd;
    int code;
    int test_errs;
    int n_tests;
    int n_bad_tests;
    bit aborted;
    bit done;

    mips_id_ex u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .id_valid      (id_valid),
        .instr         (instr),
        .pc            (pc),
        .wb_en         (wb_en),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .next_pc_sel   (next_pc_sel),
        .branch_target (branch_target),
        .jump_target   (jump_target),
        .jr_target     (jr_target),
        .ex_out        (ex_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #20000;
        $display("simulation ran past its time limit");
        $display("Testbench failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checking helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic expect_eq(input string field, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] %0s %0s expected %h actual %h", test_name, field, exp, act);
            test_errs++;
        end
    endtask

    task automatic close_test();
        n_tests++;
        if (test_errs == 0) begin
            $display("[ OK ] %0s", test_name);
        end else begin
            $display("[BAD ] %0s, %0d wrong values", test_name, test_errs);
            n_bad_tests++;
        end
        test_errs = 0;
    endtask

    task automatic check_reset();
        test_name = "reset";
        expect_eq("ex_valid", 32'd0, ex_out.valid);
        expect_eq("reg_write", 32'd0, ex_out.reg_write);
        expect_eq("mem_wen", 32'd0, ex_out.mem_wen);
        expect_eq("next_pc_sel", 32'h8, next_pc_sel);
        close_test();
    endtask

    task automatic apply_write(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk);
        id_valid = 1'b0;
        wb_en    = 1'b1;
        wb_addr  = addr[4:0];
        wb_data  = data;
        @(posedge clk);          // write lands here and reads next cycle
    endtask

    task automatic run_test();
        int waited;
        @(negedge clk);
        wb_en    = 1'b0;
        id_valid = v_valid[0];
        pc       = v_pc;
        instr    = v_instr;
        #1;                      // decode path settles
        expect_eq("next_pc_sel", v_sel, next_pc_sel);
        case (v_sel)
            32'h4:   expect_eq("branch_target", v_target, branch_target);
            32'h2:   expect_eq("jump_target", v_target, jump_target);
            32'h1:   expect_eq("jr_target", v_target, jr_target);
            default: ;
        endcase
        @(posedge clk);
        #1;
        waited = 0;
        while (v_valid[0] && !ex_out.valid && waited < MAX_WAIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (waited >= MAX_WAIT) begin
            $display("timed out waiting for ex_out.valid in test %0s", test_name);
            aborted = 1'b1;
        end else if (waited != 0) begin
            $display("[FAIL] %0s latency expected 1 actual %0d", test_name, waited + 1);
            test_errs++;
        end
        expect_eq("ex_valid", v_valid, ex_out.valid);
        expect_eq("reg_write", v_rw, ex_out.reg_write);
        expect_eq("mem_wen", v_memf[5], ex_out.mem_wen);
        if (v_valid[0]) begin
            expect_eq("alu_result", v_alu, ex_out.alu_result);
            expect_eq("dest", v_dest, ex_out.dest);
            expect_eq("mem_flags", v_memf, {ex_out.mem_wen, ex_out.mem_w, ex_out.mem_h,
                                            ex_out.mem_b, ex_out.mem_hu, ex_out.mem_bu});
            // loads are memory accesses without a write
            expect_eq("wb_is_mem", (v_memf != 0) && !v_memf[5], ex_out.wb_is_mem);
            expect_eq("store_data", v_sdata, ex_out.store_data);
        end
        close_test();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        rst_n       = 1'b0;
        id_valid    = 1'b0;
        instr       = '0;
        pc          = '0;
        wb_en       = 1'b0;
        wb_addr     = '0;
        wb_data     = '0;
        test_errs   = 0;
        n_tests     = 0;
        n_bad_tests = 0;
        aborted     = 1'b0;
        done        = 1'b0;

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_reset();

        fd = $fopen("mips_id_ex_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open mips_id_ex_vectors.txt");
            aborted = 1'b1;
        end
        while (fd != 0 && !aborted && !done) begin
            code = $fscanf(fd, "%s", kind);
            if (code != 1) begin
                done = 1'b1;
            end else if (kind == "#") begin
                code = $fgets(line, fd);
            end else if (kind == "W") begin
                code = $fscanf(fd, "%h %h", v_addr, v_data);
                if (code != 2) begin
                    $display("malformed register preload line in vector file");
                    aborted = 1'b1;
                end else begin
                    apply_write(v_addr, v_data);
                end
            end else if (kind == "T") begin
                code = $fscanf(fd, "%s %h %h %h %h %h %h %h %h %h %h", test_name, v_pc,
                               v_instr, v_valid, v_sel, v_target, v_alu, v_dest, v_rw,
                               v_memf, v_sdata);
                if (code != 11) begin
                    $display("malformed test line in vector file");
                    aborted = 1'b1;
                end else begin
                    run_test();
                end
            end else begin
                $display("unknown line kind %0s in vector file", kind);
                aborted = 1'b1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        @(negedge clk);
        wb_en    = 1'b0;
        id_valid = 1'b0;
        $display("tests %0d, ok %0d, with errors %0d",
                 n_tests, n_tests - n_bad_tests, n_bad_tests);
        if (n_bad_tests == 0 && !aborted) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: mips_id_ex_vectors.txt
# W addr data | T name pc instr valid sel(8 seq 4 br 2 j 1 jr) target alu dest rw memf sdata
# memf bits are mem_wen mem_w mem_h mem_b mem_hu mem_bu, all values hex
W 01 00000005
W 02 00000003
W 03 fffffff0
W 04 80000000
W 05 00001000
W 06 12345678
W 07 00400020
W 08 00000004
T add 00000100 00224820 1 8 00000000 00000008 09 1 00 00000003
T sub 00000104 00235022 1 8 00000000 00000015 0a 1 00 fffffff0
T slt 00000108 0061582a 1 8 00000000 00000001 0b 1 00 00000005
T sltu 0000010c 0061602b 1 8 00000000 00000000 0c 1 00 00000005
T sll 00000110 00016900 1 8 00000000 00000050 0d 1 00 00000005
T sra 00000114 00037083 1 8 00000000 fffffffc 0e 1 00 fffffff0
T srlv 00000118 01047806 1 8 00000000 08000000 0f 1 00 80000000
T lui 0000011c 3c101234 1 8 00000000 12340000 10 1 00 00000000
T andi 00000120 3071ff00 1 8 00000000 0000ff00 11 1 00 00000000
T addi 00000124 2032fff9 1 8 00000000 fffffffe 12 1 00 00000000
T beq_taken 00001000 10210003 1 4 00001010 00000000 01 0 00 00000005
T beq_not 00001000 10220003 1 8 00000000 00000000 02 0 00 00000003
T bne_back 00001000 1422fffc 1 4 00000ff4 00000000 02 0 00 00000003
T blez 00001000 18600008 1 4 00001024 00000000 00 0 00 00000000
T bgtz_not 00001000 1c600008 1 8 00000000 00000000 00 0 00 00000000
T bltz 00001000 04800001 1 4 00001008 00000000 00 0 00 00000000
T bgez 00001000 04210002 1 4 0000100c 00000000 01 0 00 00000005
T bgezal_not 00001000 04910002 1 8 00000000 00001008 1f 1 00 00000000
T j 10000100 08000040 1 2 10000100 00000000 00 0 00 00000000
T jal 10000100 0c100000 1 2 10400000 10000108 1f 1 00 00000000
T jr 10000100 00e00008 1 1 00400020 00000000 00 0 00 00000000
T jalr 00000200 00e0a009 1 1 00400020 00000208 14 1 00 00000000
T lw 00002000 8cb50008 1 8 00000000 00001008 15 1 10 00000000
T lbu 00002000 90b6ffff 1 8 00000000 00000fff 16 1 01 00000000
T lh 00002000 84b70002 1 8 00000000 00001002 17 1 08 00000000
T sw 00002000 aca6000c 1 8 00000000 0000100c 06 0 30 12345678
T sb 00002000 a0a6fffc 1 8 00000000 00000ffc 06 0 24 12345678
T beq_bubble 00001000 10210003 0 8 00000000 00000000 00 0 00 00000000
T sw_bubble 00002000 aca6000c 0 8 00000000 00000000 00 0 00 00000000
W 00 deadbeef
T addu_r0 00000300 0001c021 1 8 00000000 00000005 18 1 00 00000005

// File: mips_id_ex.f
mips_pkg.sv
branch_ctrl.sv
control.sv
reg_file.sv
alu.sv
ex_stage.sv
mips_id_ex.sv
tb_mips_id_ex.sv
